// File: verilog/sd_wr_macros.svh
/*
 * Fixed constants of the SD block writer: block size, preamble and response
 * timing, and the default SD clock divider. Include wherever one is needed.
 */
`ifndef SD_WR_MACROS_SVH
`define SD_WR_MACROS_SVH

// payload bytes in one data block
`define SD_WR_BLOCK_BYTES 512

// SD clock periods of DAT all high before the start bit
`define SD_WR_PRE_CYCLES 2

// SD clock periods to wait for the CRC status token start bit
`define SD_WR_RESP_TIMEOUT 64

// system clocks per SD clock half period, so sdclk = clk / (2 * this)
`define SD_WR_CLK_HALF 2

`endif

// File: verilog/sd_wr_pkg.sv
/*
 * Shared types of the SD block writer. Modules import it inside their
 * bodies and use scoped names in port lists.
 */
package sd_wr_pkg;

    typedef logic [3:0]  sd_dat_t;     // DAT[3:0] lanes
    typedef logic [7:0]  wr_byte_t;    // one payload byte
    typedef logic [8:0]  byte_ptr_t;   // payload byte index, 0..511
    typedef logic [12:0] bit_cnt_t;    // timer count, 4096 data cycles plus margin
    typedef logic [15:0] crc16_t;      // per-lane CRC16
    typedef logic [2:0]  crc_token_t;  // status bits of the card's CRC token

    // block write sequence, one DAT frame then the card's answer
    typedef enum logic [3:0] {
        WR_IDLE,       // waiting for start_i
        WR_PRE,        // DAT high, clock running
        WR_START,      // start bit
        WR_DATA,       // 512 payload bytes
        WR_CRC,        // 16 crc bits per lane
        WR_END,        // end bit
        WR_WAIT_RESP,  // lines released, wait for token start bit
        WR_RESP,       // three token bits and the token end bit
        WR_BUSY,       // card holds DAT0 low while programming
        WR_DONE        // report and stop the clock
    } wr_state_e;

endpackage

// File: verilog/sd_timer_if.sv
/*
 * Link between the block-write FSM and the SD clock timer. The FSM runs
 * the clock and loads segment lengths; the timer returns tick and zero.
 */
`timescale 1ns/1ps

interface sd_timer_if;
    import sd_wr_pkg::*;

    logic     run;       // sd clock enabled while high
    logic     tick;      // one clk pulse, on the clk that sdclk falls
    logic     load;      // load the down-counter, wins over decrement
    bit_cnt_t load_val;  // remaining ticks of the segment minus one
    logic     zero;      // down-counter at zero

    modport fsm_mp (
        output run,
        output load,
        output load_val,
        input  tick,
        input  zero
    );

    modport timer_mp (
        input  run,
        input  load,
        input  load_val,
        output tick,
        output zero
    );

endinterface

// File: verilog/sd_wr_timer.sv
/*
 * SD clock generator for the writer. Divides clk into sdclk_o while run is
 * high, strobes tick at each sdclk fall and keeps the segment down-counter.
 */
`timescale 1ns/1ps
`include "sd_wr_macros.svh"

module sd_wr_timer #(
    parameter int CLK_HALF = `SD_WR_CLK_HALF  // clk cycles per sdclk half period, 1 or more
) (
    input  logic         clk,
    input  logic         rst_n,
    sd_timer_if.timer_mp tmr,
    output logic         sdclk_o
);
    import sd_wr_pkg::*;

    localparam int DIV_W = (CLK_HALF > 1) ? $clog2(CLK_HALF) : 1;

    logic [DIV_W-1:0] div_q;     // clk count within the half period
    logic             half_end;  // last clk of a half period
    bit_cnt_t         cnt_q;     // segment / timeout down-counter

    assign half_end = (div_q == DIV_W'(CLK_HALF - 1));

    // fires on the clk edge that takes sdclk low
    assign tmr.tick = tmr.run & half_end & sdclk_o;
    assign tmr.zero = (cnt_q == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_q   <= '0;
            sdclk_o <= 1'b0;
        end else if (!tmr.run) begin
            div_q   <= '0;     // parked low, first half period is low
            sdclk_o <= 1'b0;
        end else if (half_end) begin
            div_q   <= '0;
            sdclk_o <= ~sdclk_o;
        end else begin
            div_q   <= div_q + 1'b1;
        end
    end

    // load wins, otherwise count ticks down and hold at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (tmr.load) begin
            cnt_q <= tmr.load_val;
        end else if (tmr.tick && !tmr.zero) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

endmodule

// File: verilog/sd_crc16_lanes.sv
/*
 * Four CRC16 (CCITT, x^16+x^12+x^5+1) generators, one per DAT lane.
 * Cleared before the data, updated per data bit, then shifted out MSB first.
 */
`timescale 1ns/1ps

module sd_crc16_lanes (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clr_i,        // zero all lanes
    input  logic              upd_i,        // fold lane_bits_i in
    input  logic              shift_i,      // move the next crc bit to the MSB
    input  sd_wr_pkg::sd_dat_t lane_bits_i,
    output sd_wr_pkg::sd_dat_t crc_bits_o    // current MSB of each lane
);
    import sd_wr_pkg::*;

    localparam crc16_t CRC_POLY = 16'h1021;

    crc16_t crc_q [4];

    // one serial step, bit in at the top
    function automatic crc16_t crc16_step(input crc16_t crc, input logic din);
        logic fb;
        fb = crc[15] ^ din;
        return {crc[14:0], 1'b0} ^ (fb ? CRC_POLY : 16'h0000);
    endfunction

    for (genvar ln = 0; ln < 4; ln++) begin : g_lane
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                crc_q[ln] <= '0;
            end else if (clr_i) begin
                crc_q[ln] <= '0;
            end else if (upd_i) begin
                crc_q[ln] <= crc16_step(crc_q[ln], lane_bits_i[ln]);
            end else if (shift_i) begin
                crc_q[ln] <= {crc_q[ln][14:0], 1'b0};  // zero fill, all 16 go out
            end
        end

        assign crc_bits_o[ln] = crc_q[ln][15];
    end

endmodule

// File: verilog/sd_dat_serializer.sv
/*
 * DAT line driver of the writer. Fetches payload bytes, emits them as bits
 * (1-bit bus) or nibbles (4-bit bus), steers the CRC block and registers
 * the start, data, CRC and end values onto DAT at each SD clock fall.
 */
`timescale 1ns/1ps
`include "sd_wr_macros.svh"

module sd_dat_serializer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 tick_i,       // sdclk falling edge strobe
    input  logic                 seg_start_i,  // fsm in start bit
    input  logic                 seg_data_i,   // fsm in payload
    input  logic                 seg_crc_i,    // fsm in crc
    input  logic                 drive_i,      // host owns the DAT lines
    input  logic                 mode4_i,      // 4-bit bus
    input  sd_wr_pkg::wr_byte_t  byte_i,
    input  sd_wr_pkg::sd_dat_t   crc_bits_i,
    output sd_wr_pkg::byte_ptr_t byte_ptr_o,
    output sd_wr_pkg::sd_dat_t   sd_dat_o,
    output logic                 sd_dat_oe_o,
    output logic                 crc_clr_o,
    output logic                 crc_upd_o,
    output logic                 crc_shift_o,
    output sd_wr_pkg::sd_dat_t   lane_bits_o
);
    import sd_wr_pkg::*;

    localparam byte_ptr_t LAST_BYTE = byte_ptr_t'(`SD_WR_BLOCK_BYTES - 1);

    wr_byte_t cur_byte_q;   // byte being shifted out
    logic [2:0] bit_pos_q;  // msb of the next bit or nibble, 7 down
    logic     fetch_q;      // pointer moved last tick, take byte_i now
    logic     end_of_byte;  // this tick sends the last bit or nibble
    logic     byte_done;
    sd_dat_t  data_bits;    // payload value for this tick
    sd_dat_t  crc_val;      // crc value for this tick

    assign end_of_byte = mode4_i ? (bit_pos_q == 3'd3) : (bit_pos_q == 3'd0);
    assign byte_done   = tick_i & seg_data_i & end_of_byte;

    // bit_pos is 7 or 3 in 4-bit mode, picking the high or low nibble
    assign data_bits = mode4_i ? (bit_pos_q[2] ? cur_byte_q[7:4] : cur_byte_q[3:0])
                               : {3'b111, cur_byte_q[bit_pos_q]};
    assign crc_val   = mode4_i ? crc_bits_i : {3'b111, crc_bits_i[0]};

    assign lane_bits_o = data_bits;           // crc sees exactly what goes on DAT
    assign crc_clr_o   = tick_i & seg_start_i;
    assign crc_upd_o   = tick_i & seg_data_i;
    assign crc_shift_o = tick_i & seg_crc_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sd_dat_o    <= 4'hF;
            sd_dat_oe_o <= 1'b1;
        end else if (tick_i) begin
            sd_dat_oe_o <= drive_i;
            if (seg_start_i) begin
                sd_dat_o <= mode4_i ? 4'h0 : 4'hE;  // start bit, lane 0 only in 1-bit mode
            end else if (seg_data_i) begin
                sd_dat_o <= data_bits;
            end else if (seg_crc_i) begin
                sd_dat_o <= crc_val;
            end else begin
                sd_dat_o <= 4'hF;  // preamble, end bit and idle
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_ptr_o <= '0;
            bit_pos_q  <= 3'd7;
            fetch_q    <= 1'b0;
        end else begin
            fetch_q <= tick_i & (seg_start_i | (seg_data_i & end_of_byte));
            if (tick_i && seg_start_i) begin
                byte_ptr_o <= '0;    // first byte is fetched during the start bit
                bit_pos_q  <= 3'd7;
            end else if (tick_i && seg_data_i) begin
                bit_pos_q <= bit_pos_q - (mode4_i ? 3'd4 : 3'd1);  // wraps back to 7
                if (byte_done) begin
                    byte_ptr_o <= (byte_ptr_o == LAST_BYTE) ? '0 : byte_ptr_o + 1'b1;
                end
            end
        end
    end

    // source has had one clk since the pointer moved
    always_ff @(posedge clk) begin
        if (fetch_q) begin
            cur_byte_q <= byte_i;
        end
    end

endmodule

// File: verilog/sd_wr_fsm.sv
/*
 * Block-write sequencer. Walks preamble, start, data, CRC and end bit,
 * then listens on DAT0 for the CRC status token and the busy phase.
 * Every step except the start request happens on the SD clock tick.
 */
`timescale 1ns/1ps
`include "sd_wr_macros.svh"

module sd_wr_fsm (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start_i,     // one clk pulse, ignored while busy
    input  logic       bus_4bit_i,
    input  logic       dat0_i,      // card's DAT0 as seen by the host
    sd_timer_if.fsm_mp tmr,
    output logic       seg_start_o,
    output logic       seg_data_o,
    output logic       seg_crc_o,
    output logic       drive_o,
    output logic       mode4_o,     // bus mode held for the whole block
    output logic       busy_o,
    output logic       done_o,
    output logic       crc_ok_o,
    output logic       timeout_o
);
    import sd_wr_pkg::*;

    // segment lengths minus one, the counter leaves on its zero tick
    localparam bit_cnt_t PRE_LEN   = bit_cnt_t'(`SD_WR_PRE_CYCLES - 1);
    localparam bit_cnt_t DATA4_LEN = bit_cnt_t'(`SD_WR_BLOCK_BYTES * 2 - 1);
    localparam bit_cnt_t DATA1_LEN = bit_cnt_t'(`SD_WR_BLOCK_BYTES * 8 - 1);
    localparam bit_cnt_t CRC_LEN   = bit_cnt_t'(15);
    localparam bit_cnt_t RESP_LEN  = bit_cnt_t'(3);   // three status bits plus end bit
    localparam bit_cnt_t WAIT_LEN  = bit_cnt_t'(`SD_WR_RESP_TIMEOUT - 1);
    localparam crc_token_t TOKEN_OK = 3'b010;

    wr_state_e  state_q;
    wr_state_e  state_d;
    logic       load_d;
    bit_cnt_t   load_val_d;
    crc_token_t token_q;    // status bits, first bit ends up at the top
    logic       seg_end;    // last tick of the current timed segment

    assign seg_end = tmr.tick & tmr.zero;

    always_comb begin
        state_d    = state_q;
        load_d     = 1'b0;
        load_val_d = '0;
        case (state_q)
            WR_IDLE: if (start_i) begin
                state_d    = WR_PRE;
                load_d     = 1'b1;
                load_val_d = PRE_LEN;
            end
            WR_PRE: if (seg_end) begin
                state_d = WR_START;
                load_d  = 1'b1;      // one period, count 0
            end
            WR_START: if (seg_end) begin
                state_d    = WR_DATA;
                load_d     = 1'b1;
                load_val_d = mode4_o ? DATA4_LEN : DATA1_LEN;
            end
            WR_DATA: if (seg_end) begin
                state_d    = WR_CRC;
                load_d     = 1'b1;
                load_val_d = CRC_LEN;
            end
            WR_CRC: if (seg_end) begin
                state_d = WR_END;
                load_d  = 1'b1;
            end
            WR_END: if (seg_end) begin
                state_d    = WR_WAIT_RESP;
                load_d     = 1'b1;
                load_val_d = WAIT_LEN;
            end
            WR_WAIT_RESP: if (tmr.tick) begin
                if (!dat0_i) begin   // token start bit
                    state_d    = WR_RESP;
                    load_d     = 1'b1;
                    load_val_d = RESP_LEN;
                end else if (tmr.zero) begin
                    state_d = WR_DONE;  // silent card
                end
            end
            WR_RESP:  if (seg_end) state_d = WR_BUSY;
            WR_BUSY:  if (tmr.tick && dat0_i) state_d = WR_DONE;  // busy released
            WR_DONE:  if (tmr.tick) state_d = WR_IDLE;
            default:  state_d = WR_IDLE;
        endcase
    end

    assign tmr.load     = load_d;
    assign tmr.load_val = load_val_d;
    assign tmr.run      = busy_o;

    assign busy_o      = (state_q != WR_IDLE);
    assign seg_start_o = (state_q == WR_START);
    assign seg_data_o  = (state_q == WR_DATA);
    assign seg_crc_o   = (state_q == WR_CRC);
    assign drive_o     = !(state_q inside {WR_WAIT_RESP, WR_RESP, WR_BUSY});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= WR_IDLE;
            mode4_o   <= 1'b0;
            token_q   <= '0;
            done_o    <= 1'b0;
            crc_ok_o  <= 1'b0;
            timeout_o <= 1'b0;
        end else begin
            state_q <= state_d;
            done_o  <= (state_q == WR_DONE) & tmr.tick;  // lands with busy_o low
            if (state_q == WR_IDLE && start_i) begin
                mode4_o   <= bus_4bit_i;
                token_q   <= '0;
                crc_ok_o  <= 1'b0;
                timeout_o <= 1'b0;
            end
            if (state_q == WR_WAIT_RESP && tmr.tick && dat0_i && tmr.zero) begin
                timeout_o <= 1'b1;
            end
            if (state_q == WR_RESP && tmr.tick) begin
                if (!tmr.zero) begin
                    token_q <= {token_q[1:0], dat0_i};
                end else begin
                    crc_ok_o <= (token_q == TOKEN_OK);  // dat0 here is the token end bit
                end
            end
        end
    end

endmodule

// File: verilog/sd_block_writer.sv
/*
 * SD card data-block writer, DAT side only. Pulse start_i to send one
 * 512-byte block from the byte source; done_o reports the card's verdict.
 */
`timescale 1ns/1ps
`include "sd_wr_macros.svh"

module sd_block_writer #(
    parameter int CLK_HALF = `SD_WR_CLK_HALF  // sdclk = clk / (2 * CLK_HALF)
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_i,
    input  logic                 bus_4bit_i,  // sampled when the block starts
    input  sd_wr_pkg::wr_byte_t  byte_i,      // byte at byte_ptr_o, one clk after it moves
    input  sd_wr_pkg::sd_dat_t   sd_dat_i,
    output logic                 sdclk_o,
    output sd_wr_pkg::sd_dat_t   sd_dat_o,
    output logic                 sd_dat_oe_o,
    output sd_wr_pkg::byte_ptr_t byte_ptr_o,
    output logic                 busy_o,
    output logic                 done_o,
    output logic                 crc_ok_o,
    output logic                 timeout_o
);
    import sd_wr_pkg::*;

    sd_timer_if tmr_if ();

    logic    seg_start;
    logic    seg_data;
    logic    seg_crc;
    logic    drive;
    logic    mode4;
    logic    crc_clr;
    logic    crc_upd;
    logic    crc_shift;
    sd_dat_t lane_bits;
    sd_dat_t crc_bits;

    sd_wr_timer #(
        .CLK_HALF (CLK_HALF)
    ) timer_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .tmr     (tmr_if.timer_mp),
        .sdclk_o (sdclk_o)
    );

    sd_wr_fsm fsm_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .bus_4bit_i  (bus_4bit_i),
        .dat0_i      (sd_dat_i[0]),
        .tmr         (tmr_if.fsm_mp),
        .seg_start_o (seg_start),
        .seg_data_o  (seg_data),
        .seg_crc_o   (seg_crc),
        .drive_o     (drive),
        .mode4_o     (mode4),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .crc_ok_o    (crc_ok_o),
        .timeout_o   (timeout_o)
    );

    sd_dat_serializer ser_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .tick_i      (tmr_if.tick),
        .seg_start_i (seg_start),
        .seg_data_i  (seg_data),
        .seg_crc_i   (seg_crc),
        .drive_i     (drive),
        .mode4_i     (mode4),
        .byte_i      (byte_i),
        .crc_bits_i  (crc_bits),
        .byte_ptr_o  (byte_ptr_o),
        .sd_dat_o    (sd_dat_o),
        .sd_dat_oe_o (sd_dat_oe_o),
        .crc_clr_o   (crc_clr),
        .crc_upd_o   (crc_upd),
        .crc_shift_o (crc_shift),
        .lane_bits_o (lane_bits)
    );

    sd_crc16_lanes crc_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .clr_i       (crc_clr),
        .upd_i       (crc_upd),
        .shift_i     (crc_shift),
        .lane_bits_i (lane_bits),
        .crc_bits_o  (crc_bits)
    );

endmodule

// File: test/sd_card_model.sv
/*
 * Behavioral SD card, DAT side of a block write. Captures payload bytes and
 * the per-lane CRC on rising sdclk, then answers on DAT0 with a CRC status
 * token and a busy time, or stays silent. The testbench reads its captures.
 */
`timescale 1ns/1ps
`include "sd_wr_macros.svh"

module sd_card_model (
    input  logic                  sdclk_i,
    input  sd_wr_pkg::sd_dat_t    dat_i,       // host DAT lines
    input  logic                  dat_oe_i,    // host drives DAT
    input  logic                  mode4_i,     // bus width of this block
    input  sd_wr_pkg::crc_token_t token_i,     // status bits to answer with
    input  int                    busy_len_i,  // sdclk periods of busy after the token
    input  logic                  silent_i,    // never answer
    output sd_wr_pkg::sd_dat_t    dat_o
);
    import sd_wr_pkg::*;

    localparam int PH_IDLE  = 0;
    localparam int PH_DATA  = 1;
    localparam int PH_CRC   = 2;
    localparam int PH_END   = 3;
    localparam int PH_REPLY = 4;

    wr_byte_t rx_bytes [`SD_WR_BLOCK_BYTES];  // payload as received
    crc16_t   rx_crc [4];                     // crc bits as received per lane
    logic     hi_lane_low = 1'b0;             // lane 1..3 seen low in 1-bit mode
    logic     start_bad = 1'b0;               // start bit lanes wrong for the bus width
    logic     oe_clash = 1'b0;                // host still driving while the card answers
    logic     end_bad = 1'b0;                 // end bit not all ones
    int       frames = 0;                     // complete frames received
    int       phase = PH_IDLE;
    int       cnt = 0;                        // sdclk periods within the phase
    wr_byte_t sh = '0;                        // partial byte
    logic     d0_q = 1'b1;                    // card side of DAT0

    assign dat_o = {3'b111, d0_q};  // card only ever answers on DAT0

    always @(posedge sdclk_i) begin
        case (phase)
            PH_IDLE: if (dat_oe_i && !dat_i[0]) begin  // start bit
                phase       <= PH_DATA;
                cnt         <= 0;
                end_bad     <= 1'b0;
                oe_clash    <= 1'b0;
                start_bad   <= (dat_i[3:1] != (mode4_i ? 3'b000 : 3'b111));
                hi_lane_low <= !mode4_i && (dat_i[3:1] != 3'b111);
            end
            PH_DATA: begin
                if (mode4_i) begin
                    sh <= {sh[3:0], dat_i};  // high nibble arrives first
                    if (cnt % 2 == 1) rx_bytes[cnt / 2] <= {sh[3:0], dat_i};
                end else begin
                    sh <= {sh[6:0], dat_i[0]};
                    if (cnt % 8 == 7) rx_bytes[cnt / 8] <= {sh[6:0], dat_i[0]};
                end
                if (cnt == (mode4_i ? 2 : 8) * `SD_WR_BLOCK_BYTES - 1) begin
                    phase <= PH_CRC;
                    cnt   <= 0;
                end else begin
                    cnt <= cnt + 1;
                end
            end
            PH_CRC: begin
                for (int ln = 0; ln < 4; ln++) rx_crc[ln] <= {rx_crc[ln][14:0], dat_i[ln]};
                if (cnt == 15) phase <= PH_END;
                cnt <= cnt + 1;
            end
            PH_END: begin
                end_bad <= (dat_i != 4'hF);
                frames  <= frames + 1;
                cnt     <= 0;
                phase   <= silent_i ? PH_IDLE : PH_REPLY;
            end
            default: begin  // token two periods after the end bit and busy after it
                if (dat_oe_i) oe_clash <= 1'b1;  // lines must be released by now
                if (cnt == 1) d0_q <= 1'b0;
                else if (cnt >= 2 && cnt <= 4) d0_q <= token_i[4 - cnt];  // msb first
                else if (cnt == 5) d0_q <= 1'b1;                          // token end bit
                else if (cnt >= 6 && cnt < 6 + busy_len_i) d0_q <= 1'b0;   // programming
                else if (cnt >= 6) begin
                    d0_q  <= 1'b1;
                    phase <= PH_IDLE;
                end
                cnt <= cnt + 1;
            end
        endcase
        if (!mode4_i && (phase == PH_DATA || phase == PH_CRC || phase == PH_END)
            && dat_i[3:1] != 3'b111) begin
            hi_lane_low <= 1'b1;
        end
    end

endmodule

// File: test/tb_sd_block_writer.sv
/*
 * Testbench for the SD block writer. Sends LFSR payload blocks in 4-bit and
 * 1-bit mode to a behavioral card and checks bytes, lane CRCs and flags.
 */
`timescale 1ns/1ps
`include "sd_wr_macros.svh"

module tb_sd_block_writer;
    import sd_wr_pkg::*;

    localparam int CLK_HALF = `SD_WR_CLK_HALF;
    localparam int BLOCK    = `SD_WR_BLOCK_BYTES;
    localparam int BLOCKS   = 5;   // blocks in the sequence below
    localparam int BUSY_MAX = 30;  // longest card busy used below
    localparam longint WATCH_NS = longint'(BLOCKS) * 2 * CLK_HALF * 40
                                  * (4096 + 200 + `SD_WR_RESP_TIMEOUT + BUSY_MAX);

    logic       clk = 1'b0;
    logic       rst_n;
    logic       start_i;
    logic       bus_4bit_i;
    wr_byte_t   byte_i;
    sd_dat_t    sd_dat_i = 4'hF;  // card DAT as handed to the DUT at clk fall
    logic       sdclk_o;
    sd_dat_t    sd_dat_o;
    logic       sd_dat_oe_o;
    byte_ptr_t  byte_ptr_o;
    logic       busy_o;
    logic       done_o;
    logic       crc_ok_o;
    logic       timeout_o;

    sd_dat_t    card_dat;
    logic       card_mode4;
    crc_token_t card_token;
    int         card_busy;
    logic       card_silent;

    wr_byte_t    payload [BLOCK];
    logic [31:0] lfsr_q = 32'he4fd_bfde;
    int          done_cnt = 0;
    logic        exp_mode4;
    logic        exp_crc_ok;
    logic        exp_timeout;

    always #20 clk = ~clk;

    always @(negedge clk) sd_dat_i <= card_dat;

    assign byte_i = payload[byte_ptr_o];  // byte source answers within the clk

    sd_block_writer #(.CLK_HALF(CLK_HALF)) dut_i (
        .clk(clk), .rst_n(rst_n), .start_i(start_i), .bus_4bit_i(bus_4bit_i),
        .byte_i(byte_i), .sd_dat_i(sd_dat_i), .sdclk_o(sdclk_o), .sd_dat_o(sd_dat_o),
        .sd_dat_oe_o(sd_dat_oe_o), .byte_ptr_o(byte_ptr_o), .busy_o(busy_o),
        .done_o(done_o), .crc_ok_o(crc_ok_o), .timeout_o(timeout_o)
    );

    sd_card_model card_i (
        .sdclk_i(sdclk_o), .dat_i(sd_dat_o), .dat_oe_i(sd_dat_oe_o), .mode4_i(card_mode4),
        .token_i(card_token), .busy_len_i(card_busy), .silent_i(card_silent),
        .dat_o(card_dat)
    );

    // right-shifting Galois form of x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    function automatic crc16_t crc_bit_in(input crc16_t c, input logic d);
        logic fb;
        fb = c[15] ^ d;
        c  = {c[14:0], 1'b0};
        return fb ? (c ^ 16'h1021) : c;
    endfunction

    // reference crc16 of one lane from the stored payload
    // in 4-bit mode the lane carries its own bit of each nibble
    function automatic crc16_t ref_lane_crc(input int lane, input logic mode4);
        crc16_t c;
        c = '0;
        for (int i = 0; i < BLOCK; i++) begin
            if (mode4) begin
                c = crc_bit_in(c, payload[i][4 + lane]);
                c = crc_bit_in(c, payload[i][lane]);
            end else begin
                for (int k = 7; k >= 0; k--) c = crc_bit_in(c, payload[i][k]);
            end
        end
        return c;
    endfunction

    task automatic fill_payload();
        wr_byte_t b;
        b = '0;
        for (int i = 0; i < BLOCK; i++) begin
            for (int k = 0; k < 8; k++) begin
                b      = {b[6:0], lfsr_q[0]};  // one step per bit
                lfsr_q = lfsr_next(lfsr_q);
            end
            payload[i] = b;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("FAIL %0t ns: %s", $time, msg);
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) report_failure($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_dat(input string what, input sd_dat_t got, input sd_dat_t exp);
        if (got !== exp) report_failure($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_byte(input int idx, input wr_byte_t got, input wr_byte_t exp);
        if (got !== exp) begin
            report_failure($sformatf("byte %0d received %h, expected %h", idx, got, exp));
        end
    endtask

    task automatic check_crc(input int lane, input crc16_t got, input crc16_t exp);
        if (got !== exp) begin
            report_failure($sformatf("lane %0d crc %h, expected %h", lane, got, exp));
        end
    endtask

    // run one block with an optional second start pulse mid block
    task automatic run_block(input logic mode4, input crc_token_t token, input int busy_len,
                             input logic silent, input int poke_byte);
        int done_before;
        int frames_before;
        fill_payload();
        card_mode4    = mode4;
        card_token    = token;
        card_busy     = busy_len;
        card_silent   = silent;
        exp_mode4     = mode4;
        exp_crc_ok    = !silent && (token == 3'b010);
        exp_timeout   = silent;
        done_before   = done_cnt;
        frames_before = card_i.frames;
        @(negedge clk);
        bus_4bit_i = mode4;
        start_i    = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        check_flag("busy_o after start", busy_o, 1'b1);
        if (poke_byte >= 0) begin
            while (byte_ptr_o != byte_ptr_t'(poke_byte)) @(negedge clk);
            start_i    = 1'b1;
            bus_4bit_i = !mode4;  // would corrupt the block if taken
            @(negedge clk);
            start_i = 1'b0;
        end
        while (done_cnt == done_before) @(negedge clk);
        repeat (16 * CLK_HALF) @(negedge clk);
        check_flag("busy_o after done", busy_o, 1'b0);
        if (done_cnt != done_before + 1) report_failure("expected exactly one done_o pulse");
        if (card_i.frames != frames_before + 1) report_failure("card did not see one frame");
    endtask

    // compare at each done pulse
    always @(negedge clk) begin
        int lanes;
        if (done_o) begin
            done_cnt++;
            check_flag("busy_o at done", busy_o, 1'b0);
            check_flag("crc_ok_o", crc_ok_o, exp_crc_ok);
            check_flag("timeout_o", timeout_o, exp_timeout);
            check_flag("start bit lane error", card_i.start_bad, 1'b0);
            check_flag("end bit error", card_i.end_bad, 1'b0);
            check_flag("host DAT drive during reply", card_i.oe_clash, 1'b0);
            for (int i = 0; i < BLOCK; i++) check_byte(i, card_i.rx_bytes[i], payload[i]);
            lanes = exp_mode4 ? 4 : 1;
            for (int ln = 0; ln < lanes; ln++) begin
                check_crc(ln, card_i.rx_crc[ln], ref_lane_crc(ln, exp_mode4));
            end
            if (!exp_mode4) check_flag("DAT3..1 low in 1-bit mode", card_i.hi_lane_low, 1'b0);
        end
    end

    initial begin
        rst_n       = 1'b0;
        start_i     = 1'b0;
        bus_4bit_i  = 1'b0;
        card_mode4  = 1'b0;
        card_token  = 3'b010;
        card_busy   = 0;
        card_silent = 1'b0;
        exp_mode4   = 1'b0;
        exp_crc_ok  = 1'b0;
        exp_timeout = 1'b0;
        fill_payload();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_flag("busy_o after reset", busy_o, 1'b0);
        check_flag("done_o after reset", done_o, 1'b0);
        check_flag("crc_ok_o after reset", crc_ok_o, 1'b0);
        check_flag("timeout_o after reset", timeout_o, 1'b0);
        check_flag("sdclk_o after reset", sdclk_o, 1'b0);
        check_flag("sd_dat_oe_o after reset", sd_dat_oe_o, 1'b1);
        check_dat("sd_dat_o after reset", sd_dat_o, 4'hF);
        run_block(1'b1, 3'b010, 12, 1'b0, -1);        // 4-bit block accepted
        run_block(1'b0, 3'b010, BUSY_MAX, 1'b0, -1);  // 1-bit block accepted
        run_block(1'b1, 3'b101, 4, 1'b0, -1);         // crc error token
        run_block(1'b1, 3'b010, 0, 1'b1, -1);         // no answer at all
        run_block(1'b1, 3'b010, 8, 1'b0, 100);        // second start mid block
        $display("Everything OK");
        $finish;
    end

    initial begin
        #(WATCH_NS);
        $display("watchdog expired, the writer never finished its blocks");
        $display("Something failed");
        $fatal(1, "run exceeded its time limit");
    end

endmodule

// File: flist.f
+incdir+verilog
verilog/sd_wr_pkg.sv
verilog/sd_timer_if.sv
verilog/sd_wr_timer.sv
verilog/sd_crc16_lanes.sv
verilog/sd_dat_serializer.sv
verilog/sd_wr_fsm.sv
verilog/sd_block_writer.sv
test/sd_card_model.sv
test/tb_sd_block_writer.sv

// File: Makefile
# Verilator build for the SD block writer testbench
VERILATOR  ?= verilator
TOP        := tb_sd_block_writer
FLIST      := flist.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing -sv
SIM_FLAGS  := --binary --timing -sv -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

# exit status of the simulation is the pass or fail result
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
